// File: dcache_ctrl.f
+incdir+.
dcache_pkg.sv
dcache_stage_if.sv
dcache_req_issue.sv
dcache_way_array.sv
dcache_line_merge.sv
dcache_load_align.sv
dcache_ctrl.sv
dcache_ctrl_assert.sv
dcache_ctrl_tb.sv

// File: dcache_ctrl.sv
// Data cache line controller
`default_nettype none
`include "dcache_defines.svh"

module dcache_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // request fifo
    input  wire logic                       req_empty,
    input  wire dcache_pkg::dc_req_t        req_head,
    output logic                            req_rd_en,
    // victim cam lookup, line returns one cycle later
    output logic [`DC_VINDEX_W-1:0]         victim_index,
    input  wire dcache_pkg::dc_line_t       victim_line,
    // eviction towards the victim cam
    output logic                            evict_valid,
    output dcache_pkg::dc_line_t            evict_line,
    // load results to the checking stage
    output logic                            load_valid,
    output logic [`DC_TAG_W-1:0]            load_tag,
    output logic [`DC_XLEN-1:0]             load_data
);

    logic [`DC_INDEX_W-1:0]     rd_index;
    dcache_pkg::dc_line_t       hit_line;
    dcache_pkg::dc_line_t       wr_line;
    dcache_pkg::dc_line_t       load_line;

    // stage-1 request shared by all sides
    dcache_stage_if st ();

    // cycle 0: hazards, pop, ram read
    dcache_req_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .req_empty    (req_empty),
        .req_head     (req_head),
        .req_rd_en    (req_rd_en),
        .victim_index (victim_index),
        .rd_index     (rd_index),
        .st           (st.issue)
    );

    // cycle 1: way select, eviction, write commit
    dcache_way_array u_array (
        .clk         (clk),
        .rst         (rst),
        .rd_index    (rd_index),
        .wr_line     (wr_line),
        .st          (st.array),
        .hit_line    (hit_line),
        .evict_valid (evict_valid),
        .evict_line  (evict_line)
    );

    // cycle 1: victim merge and line choice
    dcache_line_merge u_merge (
        .victim_line (victim_line),
        .hit_line    (hit_line),
        .st          (st.merge),
        .wr_line     (wr_line),
        .load_line   (load_line)
    );

    // cycle 1 into 2: load result register
    dcache_load_align u_align (
        .clk        (clk),
        .rst        (rst),
        .load_line  (load_line),
        .st         (st.align),
        .load_valid (load_valid),
        .load_tag   (load_tag),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// File: dcache_ctrl_assert.sv
// Controller protocol assertions
`default_nettype none

module dcache_ctrl_assert (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire logic                    req_empty,
    input wire logic                    req_rd_en,
    input wire dcache_pkg::dc_req_t     req_head,
    input wire logic                    evict_valid
);

    // number of failed properties so far
    int failures = 0;

    // no pop from an empty fifo
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        !(req_rd_en && req_empty))
    else begin
        $error("req_rd_en high while req_empty is high");
        failures++;
    end

    // evict mask on a popped request gives evict_valid one cycle later
    evict_after_pop: assert property (@(posedge clk) disable iff (rst)
        (req_rd_en && (|req_head.evict_en)) |=> evict_valid)
    else begin
        $error("evict_valid missing one cycle after an evicting pop");
        failures++;
    end

    // a hazard hold never lasts past one cycle
    hold_one_cycle: assert property (@(posedge clk) disable iff (rst)
        (!req_empty && !req_rd_en) |=> req_rd_en)
    else begin
        $error("held fifo head did not pop on the next cycle");
        failures++;
    end

endmodule

bind dcache_ctrl dcache_ctrl_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .req_empty   (req_empty),
    .req_rd_en   (req_rd_en),
    .req_head    (req_head),
    .evict_valid (evict_valid)
);

`default_nettype wire

// File: dcache_ctrl_tb.sv
// Data cache controller testbench
`default_nettype none
`include "dcache_defines.svh"

module dcache_ctrl_tb;

    localparam int n_random = 80;
    localparam int line_w   = `DC_LINE_W;

    logic                       clk;
    logic                       rst;
    logic                       req_empty;
    dcache_pkg::dc_req_t        req_head;
    logic                       req_rd_en;
    logic [`DC_VINDEX_W-1:0]    victim_index;
    dcache_pkg::dc_line_t       victim_line;
    logic                       evict_valid;
    dcache_pkg::dc_line_t       evict_line;
    logic                       load_valid;
    logic [`DC_TAG_W-1:0]       load_tag;
    logic [`DC_XLEN-1:0]        load_data;

    // expected way contents and the victim cam lines
    dcache_pkg::dc_line_t       model [`DC_WAYS][`DC_SETS];
    dcache_pkg::dc_line_t       cam [2**`DC_VINDEX_W];

    // fifo contents and results still to come, tag above data
    dcache_pkg::dc_req_t        pending [$];
    dcache_pkg::dc_line_t       exp_evict_q [$];
    logic [`DC_TAG_W+`DC_XLEN-1:0] exp_load_q [$];

    logic [31:0]                rng_state;
    logic [`DC_TAG_W-1:0]       next_tag;
    int                         errors;
    int                         checks;
    int                         total_reqs;

    dcache_ctrl DUT (
        .clk          (clk),
        .rst          (rst),
        .req_empty    (req_empty),
        .req_head     (req_head),
        .req_rd_en    (req_rd_en),
        .victim_index (victim_index),
        .victim_line  (victim_line),
        .evict_valid  (evict_valid),
        .evict_line   (evict_line),
        .load_valid   (load_valid),
        .load_tag     (load_tag),
        .load_data    (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // **************************************************
    // helpers
    // **************************************************
    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic dcache_pkg::dc_line_t rand_line();
        dcache_pkg::dc_line_t l;
        for (int i = 0; i < `DC_LINE_W / 32; i++) begin
            l[i*32 +: 32] = xorshift();
        end
        return l;
    endfunction

    // plain cache request with fresh data and the next tag
    function automatic dcache_pkg::dc_req_t new_req(input logic [`DC_INDEX_W-1:0] index,
            input logic [`DC_OFFSET_W-1:0] offset, input logic [`DC_WAYS-1:0] way);
        dcache_pkg::dc_req_t r;
        r = '0;
        r.addr.index  = index;
        r.addr.offset = offset;
        r.way_en      = way;
        r.fill_src    = dcache_pkg::FILL_CACHE;
        r.store_data  = {xorshift(), xorshift()};
        r.mem_line    = rand_line();
        r.tag         = next_tag;
        next_tag++;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [`DC_LINE_W-1:0] got,
            input logic [`DC_LINE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_value("req_rd_en", line_w'(req_rd_en), '0);
        check_value("load_valid", line_w'(load_valid), '0);
        check_value("evict_valid", line_w'(evict_valid), '0);
    endtask

    // **************************************************
    // reference model
    // **************************************************
    // old evicted line and load value of one request, then its write
    function automatic void apply_request(input dcache_pkg::dc_req_t r,
            output dcache_pkg::dc_line_t ev_line, output logic [`DC_XLEN-1:0] ld_val);
        dcache_pkg::dc_line_t   hit;
        dcache_pkg::dc_line_t   merged;
        dcache_pkg::dc_line_t   src;
        dcache_pkg::dc_line_t   wline;
        logic [`DC_XLEN-1:0]    raw;
        int                     nbytes;
        int                     base;
        ev_line = '0;
        hit     = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (r.evict_en[w]) begin
                ev_line = model[w][r.addr.index];
            end
            if (r.way_en[w]) begin
                hit = model[w][r.addr.index];
            end
        end
        // store lane lands at the offset rounded down to its size
        merged = cam[r.victim_index];
        nbytes = 1 << r.store_size;
        base   = int'(r.addr.offset) & ~(nbytes - 1);
        if (r.store_en) begin
            for (int b = 0; b < nbytes; b++) begin
                merged[(base+b)*8 +: 8] = r.store_data.dword[b*8 +: 8];
            end
        end
        case (r.fill_src)
            dcache_pkg::FILL_MEMORY: src = r.mem_line;
            dcache_pkg::FILL_VICTIM: src = merged;
            default:                 src = hit;
        endcase
        // low two bits give the size, bit 2 means zero extension
        nbytes = 1 << r.funct3[1:0];
        base   = int'(r.addr.offset) & ~(nbytes - 1);
        raw    = '0;
        for (int b = 0; b < nbytes; b++) begin
            raw[b*8 +: 8] = src[(base+b)*8 +: 8];
        end
        ld_val = raw;
        if (!r.funct3[2]) begin
            for (int i = nbytes * 8; i < `DC_XLEN; i++) begin
                ld_val[i] = raw[nbytes*8-1];
            end
        end
        if (r.funct3 == 3'd7) begin
            ld_val = '0;
        end
        wline = (r.fill_src == dcache_pkg::FILL_MEMORY) ? r.mem_line : merged;
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (r.way_en[w] && r.wr_byte_en[b]) begin
                    model[w][r.addr.index][b*8 +: 8] = wline[b*8 +: 8];
                end
            end
        end
    endfunction

    // **************************************************
    // request lists
    // **************************************************
    task automatic queue_directed();
        dcache_pkg::dc_req_t r;
        // memory fill of way 0 set 3, then every load width right behind it
        r = new_req(4'd3, 5'd0, 4'b0001);
        r.fill_src   = dcache_pkg::FILL_MEMORY;
        r.wr_byte_en = '1;
        pending.push_back(r);
        for (int f = 0; f < 8; f++) begin
            r = new_req(4'd3, 5'(f * 5), 4'b0001);
            r.is_load = 1'b1;
            r.funct3  = 3'(f);
            pending.push_back(r);
        end
        // victim merge of each store size, loaded directly and read back
        for (int s = 0; s < 4; s++) begin
            r = new_req(4'd5, 5'(s * 9 + 1), 4'b0010);
            r.fill_src     = dcache_pkg::FILL_VICTIM;
            r.wr_byte_en   = '1;
            r.store_en     = 1'b1;
            r.store_size   = 2'(s);
            r.victim_index = 3'(s);
            r.is_load      = 1'b1;
            r.funct3       = `DC_F3_LD;
            pending.push_back(r);
            r = new_req(4'd5, 5'(s * 9 + 1), 4'b0010);
            r.is_load = 1'b1;
            r.funct3  = `DC_F3_LD;
            pending.push_back(r);
        end
        // evict of a way written one request earlier
        r = new_req(4'd5, 5'd0, 4'b0010);
        r.fill_src   = dcache_pkg::FILL_MEMORY;
        r.wr_byte_en = '1;
        pending.push_back(r);
        r = new_req(4'd5, 5'd0, 4'b0001);
        r.evict_en = 4'b0010;
        pending.push_back(r);
        // evict and refill of the same way twice in a row
        for (int k = 0; k < 2; k++) begin
            r = new_req(4'd7, 5'd0, 4'b0100);
            r.evict_en   = 4'b0100;
            r.fill_src   = dcache_pkg::FILL_MEMORY;
            r.wr_byte_en = '1;
            pending.push_back(r);
        end
    endtask

    task automatic queue_random();
        dcache_pkg::dc_req_t        r;
        logic [31:0]                x;
        logic [`DC_INDEX_W-1:0]     idx;
        for (int i = 0; i < n_random; i++) begin
            x = xorshift();
            // mostly three hot sets so hazards come up often
            case (x[1:0])
                2'd0:    idx = x[5:2];
                2'd1:    idx = 4'd3;
                2'd2:    idx = 4'd5;
                default: idx = 4'd9;
            endcase
            r = new_req(idx, x[10:6], 4'b0001 << x[12:11]);
            r.fill_src = (x[14:13] == 2'd1) ? dcache_pkg::FILL_VICTIM
                       : (x[14:13] == 2'd2) ? dcache_pkg::FILL_MEMORY
                       : dcache_pkg::FILL_CACHE;
            r.is_load      = x[15];
            r.funct3       = x[18:16];
            r.evict_en     = x[19] ? (4'b0001 << x[21:20]) : 4'b0000;
            r.store_en     = x[22];
            r.store_size   = x[24:23];
            r.victim_index = x[27:25];
            case (x[29:28])
                2'd0:    r.wr_byte_en = '0;
                2'd1:    r.wr_byte_en = xorshift();
                default: r.wr_byte_en = '1;
            endcase
            pending.push_back(r);
        end
    endtask

    // **************************************************
    // stimulus and fifo model
    // **************************************************
    initial begin : stimulus
        dcache_pkg::dc_req_t    r;
        dcache_pkg::dc_line_t   ev;
        logic [`DC_XLEN-1:0]    ld;
        rng_state   = 32'h25a5;
        next_tag    = '0;
        errors      = 0;
        checks      = 0;
        total_reqs  = 0;
        rst         = 1'b1;
        req_empty   = 1'b1;
        req_head    = '0;
        victim_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                model[w][s] = '0;
            end
        end
        for (int i = 0; i < 2**`DC_VINDEX_W; i++) begin
            cam[i] = rand_line();
        end
        queue_directed();
        queue_random();
        total_reqs = pending.size();
        // outputs stay quiet through reset and while the fifo is empty
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_idle();
            end
        end
        rst <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            check_idle();
        end
        do begin
            @(posedge clk);
            if (req_rd_en === 1'b1) begin
                r = pending.pop_front();
                apply_request(r, ev, ld);
                if (|r.evict_en) begin
                    exp_evict_q.push_back(ev);
                end
                if (r.is_load) begin
                    exp_load_q.push_back({r.tag, ld});
                end
            end
            req_empty <= (pending.size() == 0);
            if (pending.size() != 0) begin
                req_head <= pending[0];
            end
        end while (pending.size() != 0);
        while (exp_load_q.size() != 0 || exp_evict_q.size() != 0) begin
            @(posedge clk);
        end
        // nothing extra may follow the last result
        repeat (3) @(posedge clk);
        errors = errors + DUT.u_assert.failures;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // victim cam answers one cycle after the lookup
    always @(posedge clk) begin
        victim_line <= cam[victim_index];
    end

    // **************************************************
    // result compare
    // **************************************************
    always @(posedge clk) begin : compare
        logic [`DC_TAG_W+`DC_XLEN-1:0] exp_ld;
        if (load_valid === 1'b1) begin
            if (exp_load_q.size() == 0) begin
                errors++;
                $display("Load result with tag %0h arrived with no load expected", load_tag);
            end else begin
                exp_ld = exp_load_q.pop_front();
                check_value("load_tag", line_w'(load_tag), line_w'(exp_ld[`DC_XLEN +: `DC_TAG_W]));
                check_value("load_data", line_w'(load_data), line_w'(exp_ld[`DC_XLEN-1:0]));
            end
        end
        if (evict_valid === 1'b1) begin
            if (exp_evict_q.size() == 0) begin
                errors++;
                $display("Eviction arrived with no eviction expected");
            end else begin
                check_value("evict_line", evict_line, exp_evict_q.pop_front());
            end
        end
    end

    // run limit from the request count
    initial begin : watchdog
        wait (total_reqs != 0);
        repeat (total_reqs * 4 + 200) @(posedge clk);
        $display("Timeout: results still outstanding after %0d cycles", total_reqs * 4 + 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_defines.svh
// Data cache geometry and encodings
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// **************************************************
// cache geometry
// **************************************************
// four ways of sixteen sets each
`define DC_WAYS         4
`define DC_SETS         16
`define DC_INDEX_W      4
// 256-bit line, one write-mask bit per byte
`define DC_LINE_W       256
`define DC_LINE_BYTES   32
`define DC_OFFSET_W     5
// load result width
`define DC_XLEN         64
// request tag and victim cam index
`define DC_TAG_W        4
`define DC_VINDEX_W     3

// **************************************************
// load function codes (risc-v funct3)
// **************************************************
`define DC_F3_LB        3'd0
`define DC_F3_LH        3'd1
`define DC_F3_LW        3'd2
`define DC_F3_LD        3'd3
`define DC_F3_LBU       3'd4
`define DC_F3_LHU       3'd5
`define DC_F3_LWU       3'd6

`endif

// File: dcache_line_merge.sv
// Victim line merge and fill select
`default_nettype none
`include "dcache_defines.svh"

module dcache_line_merge (
    input  wire dcache_pkg::dc_line_t   victim_line,
    input  wire dcache_pkg::dc_line_t   hit_line,
    dcache_stage_if.merge               st,
    output dcache_pkg::dc_line_t        wr_line,
    output dcache_pkg::dc_line_t        load_line
);

    // doubleword slot holding the store
    logic [1:0]                 dw_sel;
    logic [`DC_OFFSET_W-1:0]    offset;
    // victim doubleword before and after the store
    dcache_pkg::dc_word_u       old_dw;
    dcache_pkg::dc_word_u       new_dw;
    dcache_pkg::dc_line_t       merged_line;

    assign offset = st.s1_req.addr.offset;
    assign dw_sel = offset[4:3];

    // **************************************************
    // store insertion into the victim line (cycle 1)
    // **************************************************
    always_comb begin
        old_dw = victim_line[dw_sel*64 +: 64];
        new_dw = old_dw;
        // store value sits in the low lane of store_data
        case (st.s1_req.store_size)
            2'd0: new_dw.bytes[offset[2:0]]  = st.s1_req.store_data.bytes[0];
            2'd1: new_dw.halves[offset[2:1]] = st.s1_req.store_data.halves[0];
            2'd2: new_dw.words[offset[2]]    = st.s1_req.store_data.words[0];
            default: new_dw.dword            = st.s1_req.store_data.dword;
        endcase
        merged_line = victim_line;
        if (st.s1_req.store_en) begin
            merged_line[dw_sel*64 +: 64] = new_dw;
        end
    end

    // **************************************************
    // line selection
    // **************************************************
    // ram writes take the memory line or the merged victim line
    assign wr_line = (st.s1_req.fill_src == dcache_pkg::FILL_MEMORY)
                   ? st.s1_req.mem_line : merged_line;

    // load source follows the fill source
    always_comb begin
        case (st.s1_req.fill_src)
            dcache_pkg::FILL_MEMORY: load_line = st.s1_req.mem_line;
            dcache_pkg::FILL_VICTIM: load_line = merged_line;
            dcache_pkg::FILL_CACHE:  load_line = hit_line;
            // unused encoding reads as all ones
            default:                 load_line = '1;
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_load_align.sv
// Load extract and extend
`default_nettype none
`include "dcache_defines.svh"

module dcache_load_align (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire dcache_pkg::dc_line_t   load_line,
    dcache_stage_if.align               st,
    output logic                        load_valid,
    output logic [`DC_TAG_W-1:0]        load_tag,
    output logic [`DC_XLEN-1:0]         load_data
);

    logic [`DC_OFFSET_W-1:0]    offset;
    // addressed doubleword and its lanes
    dcache_pkg::dc_word_u       dw;
    logic [7:0]                 lb;
    logic [15:0]                lh;
    logic [31:0]                lw;
    logic [`DC_XLEN-1:0]        ext_data;

    assign offset = st.s1_req.addr.offset;
    assign dw     = load_line[offset[4:3]*64 +: 64];
    assign lb     = dw.bytes[offset[2:0]];
    assign lh     = dw.halves[offset[2:1]];
    assign lw     = dw.words[offset[2]];

    // sign or zero extension by function code
    always_comb begin
        case (st.s1_req.funct3)
            `DC_F3_LB:  ext_data = {{(`DC_XLEN-8){lb[7]}}, lb};
            `DC_F3_LH:  ext_data = {{(`DC_XLEN-16){lh[15]}}, lh};
            `DC_F3_LW:  ext_data = {{(`DC_XLEN-32){lw[31]}}, lw};
            `DC_F3_LD:  ext_data = dw.dword;
            `DC_F3_LBU: ext_data = {{(`DC_XLEN-8){1'b0}}, lb};
            `DC_F3_LHU: ext_data = {{(`DC_XLEN-16){1'b0}}, lh};
            `DC_F3_LWU: ext_data = {{(`DC_XLEN-32){1'b0}}, lw};
            default:    ext_data = '0;
        endcase
    end

    // **************************************************
    // result register, two cycles after the pop
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= st.s1_valid && st.s1_req.is_load;
        end
    end

    always_ff @(posedge clk) begin
        load_tag  <= st.s1_req.tag;
        load_data <= ext_data;
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
// Data cache shared types
`default_nettype none
`include "dcache_defines.svh"

package dcache_pkg;

    // one full cache line
    typedef logic [`DC_LINE_W-1:0] dc_line_t;

    // where the line for writes and loads comes from
    typedef enum logic [1:0] {
        FILL_CACHE  = 2'b01,
        FILL_VICTIM = 2'b10,
        FILL_MEMORY = 2'b11
    } dc_fill_src_e;

    // 64-bit data word, seen whole or split into lanes
    typedef union packed {
        logic [`DC_XLEN-1:0]            dword;
        logic [`DC_XLEN/8-1:0][7:0]     bytes;
        logic [`DC_XLEN/16-1:0][15:0]   halves;
        logic [`DC_XLEN/32-1:0][31:0]   words;
    } dc_word_u;

    // set index above the byte offset
    typedef struct packed {
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
    } dc_addr_t;

    // request as it sits at the fifo head
    typedef struct packed {
        dc_addr_t                   addr;
        logic [`DC_WAYS-1:0]        way_en;
        logic [`DC_WAYS-1:0]        evict_en;
        logic [`DC_LINE_BYTES-1:0]  wr_byte_en;
        dc_fill_src_e               fill_src;
        logic                       is_load;
        logic [2:0]                 funct3;
        logic [`DC_TAG_W-1:0]       tag;
        // 0 byte, 1 halfword, 2 word, 3 doubleword
        logic [1:0]                 store_size;
        logic                       store_en;
        dc_word_u                   store_data;
        dc_line_t                   mem_line;
        logic [`DC_VINDEX_W-1:0]    victim_index;
    } dc_req_t;

endpackage

`default_nettype wire

// File: dcache_req_issue.sv
// Request issue and hazard stall
`default_nettype none
`include "dcache_defines.svh"

module dcache_req_issue (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       req_empty,
    input  wire dcache_pkg::dc_req_t        req_head,
    output logic                            req_rd_en,
    output logic [`DC_VINDEX_W-1:0]         victim_index,
    output logic [`DC_INDEX_W-1:0]          rd_index,
    dcache_stage_if.issue                   st
);

    // head index against the write sitting in stage 1
    logic same_index;
    // load reading a way that is written at the end of this cycle
    logic raw_hazard;
    // eviction of a way that is written at the end of this cycle
    logic eaw_hazard;
    logic hold;

    // **************************************************
    // hazard detection (cycle 0)
    // **************************************************
    // ram writes land one cycle after the pop, so a read or evict of
    // the same way and index right behind a write would see stale data
    assign same_index = (req_head.addr.index == st.s1_req.addr.index);

    // only loads wait on a raw
    assign raw_hazard = st.s1_raw
                      && req_head.is_load
                      && (req_head.way_en == st.s1_req.way_en)
                      && same_index;

    // any request with an evict mask waits on an eaw
    assign eaw_hazard = st.s1_raw
                      && (|req_head.evict_en)
                      && (req_head.evict_en == st.s1_req.way_en)
                      && same_index;

    assign hold = raw_hazard || eaw_hazard;

    // pop whenever there is a head and nothing to wait for
    // a hold never lasts past one cycle since s1_raw drops without a pop
    assign req_rd_en = !req_empty && !hold;

    // **************************************************
    // lookups started from the head
    // **************************************************
    // ram read address, data comes back next cycle
    assign rd_index = req_head.addr.index;
    // victim cam line returns one cycle later
    assign victim_index = req_head.victim_index;

    // **************************************************
    // stage 1 register
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            st.s1_valid <= 1'b0;
            st.s1_raw   <= 1'b0;
        end else begin
            st.s1_valid <= req_rd_en;
            // popped request writes at least one byte
            st.s1_raw   <= req_rd_en && (|req_head.wr_byte_en);
        end
    end

    // payload follows the head every cycle, qualified by s1_valid
    always_ff @(posedge clk) begin
        st.s1_req <= req_head;
    end

endmodule

`default_nettype wire

// File: dcache_stage_if.sv
// Stage-1 request bundle
`default_nettype none

interface dcache_stage_if;

    // request accepted from the fifo in the previous cycle
    logic                   s1_valid;
    dcache_pkg::dc_req_t    s1_req;
    // stage 1 holds a write, source of read/evict-after-write hazards
    logic                   s1_raw;

    // issue side registers the popped request
    modport issue (
        output s1_valid,
        output s1_req,
        output s1_raw
    );

    // way rams use index, enables and write mask
    modport array (
        input  s1_valid,
        input  s1_req,
        input  s1_raw
    );

    // merge only needs the payload
    modport merge (
        input  s1_req
    );

    // load extract needs payload and valid
    modport align (
        input  s1_valid,
        input  s1_req
    );

endinterface

`default_nettype wire

// File: dcache_way_array.sv
// Four-way line RAM array
`default_nettype none
`include "dcache_defines.svh"

module dcache_way_array (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`DC_INDEX_W-1:0]     rd_index,
    input  wire dcache_pkg::dc_line_t       wr_line,
    dcache_stage_if.array                   st,
    output dcache_pkg::dc_line_t            hit_line,
    output logic                            evict_valid,
    output dcache_pkg::dc_line_t            evict_line
);

    // synchronous read data per way, valid in cycle 1
    dcache_pkg::dc_line_t       rd_data [`DC_WAYS];
    // byte write enables per way
    logic [`DC_LINE_BYTES-1:0]  way_we  [`DC_WAYS];

    // **************************************************
    // way rams
    // **************************************************
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_pkg::dc_line_t ram [`DC_SETS];

        // rams power up cleared
        initial begin
            for (int s = 0; s < `DC_SETS; s++) begin
                ram[s] = '0;
            end
        end

        // write mask gated by this way's enable
        // no ram writes while reset is held
        assign way_we[w] = (!rst && st.s1_raw && st.s1_req.way_en[w])
                         ? st.s1_req.wr_byte_en : '0;

        always_ff @(posedge clk) begin
            // read returns the content before a same-edge write
            rd_data[w] <= ram[rd_index];
            for (int b = 0; b < `DC_LINE_BYTES; b++) begin
                if (way_we[w][b]) begin
                    ram[st.s1_req.addr.index][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

    // **************************************************
    // hit and evict selection (cycle 1)
    // **************************************************
    // lowest enabled way wins, masks are one-hot in practice
    always_comb begin
        hit_line   = '0;
        evict_line = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (st.s1_req.way_en[w]) begin
                hit_line = rd_data[w];
            end
            if (st.s1_req.evict_en[w]) begin
                evict_line = rd_data[w];
            end
        end
    end

    // old line leaves one cycle after the pop
    assign evict_valid = st.s1_valid && (|st.s1_req.evict_en);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the data cache controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module dcache_ctrl_tb -f dcache_ctrl.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
